//--- dcache.f
+incdir+sim
common/dcache_pkg.sv
dcache/tag_data_array.sv
dcache/line_word_mux.sv
dcache/cache_ctrl.sv
dcache/dcache_top.sv
sim/dcache_properties.sv
sim/dcache_tb.sv

//--- Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
HEADERS   ?= sim/dcache_tb_tasks.svh
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/dcache_tb_tasks.svh
// data cache directed tests
// check helpers, core request driver, miss unit responder and the tests
`ifndef DCACHE_TB_TASKS_SVH
`define DCACHE_TB_TASKS_SVH

// --------------------
// checks
// --------------------
task automatic compare_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
        $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic require(input logic cond, input string what);
    assert (cond) else begin
        $display("%0t: %s", $time, what);
        abort_run();
    end
endtask

// --------------------
// core side
// --------------------
// call right after a falling edge
task automatic drive_req(input logic we, input dcache_pkg::addr_t addr,
                         input dcache_pkg::be_t be, input dcache_pkg::word_t wdata);
    core_req.req   = 1'b1;
    core_req.we    = we;
    core_req.addr  = addr;
    core_req.be    = be;
    core_req.wdata = wdata;
endtask

// returns at the rising edge that shows gnt
task automatic wait_core_gnt();
    int unsigned n;
    n = 0;
    @(posedge clk);
    while (!core_rsp.gnt) begin
        require(!miss_req.valid, "miss request raised for an access that should hit");
        n++;
        require(n < MaxWait, "timeout waiting for core gnt");
        @(posedge clk);
    end
endtask

// miss unit grants late, then sends refill and critical word for a load,
// or merges the store bytes into memory
task automatic serve_miss(input logic we, input dcache_pkg::addr_t addr,
                          input dcache_pkg::be_t be, input dcache_pkg::word_t wdata,
                          input dcache_pkg::word_t exp);
    int unsigned n;
    n = 0;
    @(posedge clk);
    while (!miss_req.valid) begin
        require(!core_rsp.gnt && !core_rsp.rvalid, "cache answered an access that should miss");
        n++;
        require(n < MaxWait, "timeout waiting for a miss request");
        @(posedge clk);
    end
    compare_value("miss_req_o.we", 64'(miss_req.we), 64'(we));
    compare_value("miss_req_o.addr", 64'(miss_req.addr), 64'(addr));
    if (we) begin
        compare_value("miss_req_o.be", 64'(miss_req.be), 64'(be));
        compare_value("miss_req_o.wdata", miss_req.wdata, wdata);
    end
    repeat (GntDelay) @(posedge clk);
    @(negedge clk);
    miss_gnt = 1'b1;
    @(posedge clk);
    // a store miss completes in the grant cycle, a load does not
    compare_value("core_rsp_o.gnt", 64'(core_rsp.gnt), 64'(we));
    @(negedge clk);
    miss_gnt     = 1'b0;
    core_req.req = 1'b0;
    if (we) begin
        mem_q[word_addr(addr)] = merge_bytes(mem_word(addr), wdata, be);
    end else begin
        refill.valid = 1'b1;
        refill.addr  = line_addr(addr);
        refill.line  = install_line(addr);
        @(negedge clk);
        refill.valid = 1'b0;
        repeat (CritDelay) @(negedge clk);
        crit_valid = 1'b1;
        crit_word  = mem_word(addr);
        @(posedge clk);
        require(core_rsp.rvalid, "no rvalid with the critical word");
        compare_value("core_rsp_o.rdata", core_rsp.rdata, exp);
        @(negedge clk);
        crit_valid = 1'b0;
    end
endtask

// one load or store, hit or miss predicted by the shadow model
task automatic access(input logic we, input dcache_pkg::addr_t addr,
                      input dcache_pkg::be_t be, input dcache_pkg::word_t wdata);
    bit                hit;
    dcache_pkg::word_t exp;
    hit = cached_q.exists(line_addr(addr));
    exp = model_word(addr);
    @(negedge clk);
    drive_req(we, addr, be, wdata);
    if (!we) begin
        wait_core_gnt();
        @(negedge clk);
        core_req.req = 1'b0;
        if (hit) begin
            @(posedge clk);
            require(core_rsp.rvalid, "no rvalid one cycle after a load hit gnt");
            compare_value("core_rsp_o.rdata", core_rsp.rdata, exp);
        end else begin
            serve_miss(we, addr, be, wdata, exp);
        end
    end else if (hit) begin
        wait_core_gnt();
        @(negedge clk);
        core_req.req = 1'b0;
        shadow_q[word_addr(addr)] = merge_bytes(exp, wdata, be);
    end else begin
        serve_miss(we, addr, be, wdata, exp);
    end
endtask

// second load is granted in the cycle of the first rvalid
task automatic back_to_back_loads(input dcache_pkg::addr_t a0, input dcache_pkg::addr_t a1);
    dcache_pkg::word_t e0;
    dcache_pkg::word_t e1;
    e0 = model_word(a0);
    e1 = model_word(a1);
    @(negedge clk);
    drive_req(1'b0, a0, '1, '0);
    wait_core_gnt();
    @(negedge clk);
    drive_req(1'b0, a1, '1, '0);
    @(posedge clk);
    require(core_rsp.rvalid, "no rvalid for the first back to back load");
    compare_value("core_rsp_o.rdata", core_rsp.rdata, e0);
    require(core_rsp.gnt, "second load not granted with the first rvalid");
    @(negedge clk);
    core_req.req = 1'b0;
    @(posedge clk);
    require(core_rsp.rvalid, "no rvalid for the second back to back load");
    compare_value("core_rsp_o.rdata", core_rsp.rdata, e1);
endtask

// --------------------
// tests
// --------------------
task automatic miss_then_refill();
    $display("%0t: load miss", $time);
    access(1'b0, make_addr(0, 2, 1'b1), '1, '0);
endtask

task automatic hit_loads();
    $display("%0t: load hits", $time);
    access(1'b0, make_addr(0, 2, 1'b0), '1, '0);
    // second way of the same set
    access(1'b0, make_addr(1, 2, 1'b0), '1, '0);
    back_to_back_loads(make_addr(0, 2, 1'b1), make_addr(1, 2, 1'b1));
endtask

task automatic partial_store_hit();
    $display("%0t: store hit", $time);
    access(1'b1, make_addr(0, 2, 1'b0), 8'b0011_0101, 64'h0123_4567_89ab_cdef);
    // first refill of set 2 went to way 0, the second one came in clean
    compare_value("tag_data_array dirty bits of set 2",
                  64'(dut_i.i_tag_data_array.dirty_q[2]), 64'(4'b0001));
    access(1'b0, make_addr(0, 2, 1'b0), '1, '0);
endtask

task automatic store_miss_forward();
    $display("%0t: store miss", $time);
    access(1'b1, make_addr(2, 5, 1'b1), 8'hf0, 64'hfeed_cafe_0bad_f00d);
    access(1'b0, make_addr(2, 5, 1'b1), '1, '0);
    access(1'b0, make_addr(2, 5, 1'b0), '1, '0);
endtask

// an unrelated refill takes the array in the request cycle
task automatic refill_blocks_grant();
    dcache_pkg::addr_t a;
    dcache_pkg::addr_t other;
    dcache_pkg::word_t exp;
    $display("%0t: refill collision", $time);
    a     = make_addr(0, 2, 1'b1);
    other = make_addr(3, 7, 1'b0);
    exp   = model_word(a);
    @(negedge clk);
    drive_req(1'b0, a, '1, '0);
    refill.valid = 1'b1;
    refill.addr  = line_addr(other);
    refill.line  = install_line(other);
    @(posedge clk);
    require(!core_rsp.gnt, "gnt given while a refill held the array");
    @(negedge clk);
    refill.valid = 1'b0;
    wait_core_gnt();
    @(negedge clk);
    core_req.req = 1'b0;
    @(posedge clk);
    require(core_rsp.rvalid, "no rvalid after the delayed gnt");
    compare_value("core_rsp_o.rdata", core_rsp.rdata, exp);
    // the refilled line must now hit
    access(1'b0, make_addr(3, 7, 1'b1), '1, '0);
endtask

task automatic random_traffic(input int unsigned count);
    logic [31:0]       r;
    dcache_pkg::addr_t a;
    dcache_pkg::word_t d;
    $display("%0t: random traffic", $time);
    for (int unsigned i = 0; i < count; i++) begin
        r = lcg_next();
        a = make_addr(int'(r[18:16]) % NumWays, int'(r[22:21]), r[19]);
        d = {lcg_next(), lcg_next()};
        access(r[20], a, r[31:24], d);
    end
endtask

`endif

//--- sim/dcache_tb.sv
`timescale 1ns/100ps
// data cache testbench
// clock, reset, DUT, memory and shadow cache model, LCG and watchdog;
// the directed tests and the miss unit responses live in the task file
module dcache_tb;

    localparam int unsigned NumWays       = 4;
    localparam int unsigned ClkPeriod     = 8;
    localparam int unsigned ResetCycles   = 5;
    localparam int unsigned NumTests      = 6;
    // cycle bound of one test sized for the long random test
    localparam int unsigned CyclesPerTest = 1000;
    localparam int unsigned MaxWait       = 64;
    // miss unit latencies
    localparam int unsigned GntDelay      = 2;
    localparam int unsigned CritDelay     = 3;

    logic                  clk;
    logic                  rst_n;
    dcache_pkg::core_req_t core_req;
    dcache_pkg::core_rsp_t core_rsp;
    dcache_pkg::miss_req_t miss_req;
    logic                  miss_gnt;
    dcache_pkg::refill_t   refill;
    logic                  crit_valid;
    dcache_pkg::word_t     crit_word;

    // memory behind the miss unit, keyed by word address
    dcache_pkg::word_t mem_q    [dcache_pkg::addr_t];
    // cached copy of every line the cache holds
    dcache_pkg::word_t shadow_q [dcache_pkg::addr_t];
    bit                cached_q [dcache_pkg::addr_t];
    logic [31:0]       lcg_state;

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    dcache_top #(
        .NumWays (NumWays)
    ) dut_i (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .core_req_i            (core_req),
        .core_rsp_o            (core_rsp),
        .miss_req_o            (miss_req),
        .miss_gnt_i            (miss_gnt),
        .refill_i              (refill),
        .critical_word_valid_i (crit_valid),
        .critical_word_i       (crit_word)
    );

    // --------------------
    // memory model
    // --------------------
    function automatic dcache_pkg::addr_t word_addr(input dcache_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic dcache_pkg::addr_t line_addr(input dcache_pkg::addr_t a);
        return {a[31:4], 4'b0000};
    endfunction

    // untouched memory holds a pattern of its own address
    function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t w;
        w = word_addr(a);
        if (mem_q.exists(w)) begin
            return mem_q[w];
        end
        return {w ^ 32'h5a5a_0f0f, ~w};
    endfunction

    // what the core should read back
    function automatic dcache_pkg::word_t model_word(input dcache_pkg::addr_t a);
        if (shadow_q.exists(word_addr(a))) begin
            return shadow_q[word_addr(a)];
        end
        return mem_word(a);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                      input dcache_pkg::word_t wdata,
                                                      input dcache_pkg::be_t   be);
        dcache_pkg::word_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // marks a line as cached and returns its refill data, upper word on top
    function automatic dcache_pkg::line_t install_line(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t base;
        base = line_addr(a);
        cached_q[base]          = 1'b1;
        shadow_q[base]          = mem_word(base);
        shadow_q[base + 32'd8]  = mem_word(base + 32'd8);
        return {shadow_q[base + 32'd8], shadow_q[base]};
    endfunction

    // tags come from a pool of NumWays per set, so no line is ever evicted
    function automatic dcache_pkg::addr_t make_addr(input int unsigned tag_sel,
                                                    input int unsigned index,
                                                    input bit          word);
        dcache_pkg::tag_t   tag;
        dcache_pkg::index_t idx;
        tag = dcache_pkg::tag_t'(32'h0000_a100 + tag_sel);
        idx = dcache_pkg::index_t'(index);
        return {tag, idx, word, 3'b000};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "dcache_tb_tasks.svh"

    // stop at the first failed protocol assertion of the bound checker
    always @(negedge clk) begin
        assert (dut_i.i_dcache_properties.error_count == 0) else begin
            $display("%0t: bound protocol assertion failed", $time);
            abort_run();
        end
    end

    initial begin : watchdog
        #(ClkPeriod * (ResetCycles + NumTests * CyclesPerTest));
        $display("%0t: watchdog expired before the tests finished", $time);
        abort_run();
    end

    initial begin : main
        lcg_state  = 32'd28024;
        rst_n      = 1'b0;
        core_req   = '0;
        miss_gnt   = 1'b0;
        refill     = '0;
        crit_valid = 1'b0;
        crit_word  = '0;
        repeat (ResetCycles) @(negedge clk);
        rst_n = 1'b1;

        miss_then_refill();
        hit_loads();
        partial_store_hit();
        store_miss_forward();
        refill_blocks_grant();
        random_traffic(60);

        @(negedge clk);
        if (dut_i.i_dcache_properties.error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut_i.i_dcache_properties.error_count);
            abort_run();
        end
    end

endmodule

//--- sim/dcache_properties.sv
`timescale 1ns/100ps
// protocol properties of the data cache top level
// miss request hold, response exclusivity and quiet outputs in reset
module dcache_properties (
    input logic                  clk_i,
    input logic                  rst_ni,
    input dcache_pkg::core_rsp_t core_rsp_i,
    input dcache_pkg::miss_req_t miss_req_i,
    input logic                  miss_gnt_i
);

    // number of failed assertions
    int unsigned error_count = 0;

    // a miss request holds its fields until the miss unit takes it
    miss_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i.valid && !miss_gnt_i |=> miss_req_i.valid && $stable(miss_req_i))
    else begin
        error_count++;
        $error("miss request dropped or changed before miss_gnt");
    end

    // a load ends either on rvalid or waits on the miss unit
    rvalid_miss_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(core_rsp_i.rvalid && miss_req_i.valid))
    else begin
        error_count++;
        $error("rvalid and miss request high together");
    end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !core_rsp_i.gnt && !core_rsp_i.rvalid)
    else begin
        error_count++;
        $error("gnt or rvalid during reset");
    end

endmodule

bind dcache_top dcache_properties i_dcache_properties (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .core_rsp_i (core_rsp_o),
    .miss_req_i (miss_req_o),
    .miss_gnt_i (miss_gnt_i)
);

//--- dcache/dcache_top.sv
`timescale 1ns/100ps
// blocking set associative data cache
// controller, hit way and word logic, and the tag/data array
module dcache_top #(
    parameter int unsigned NumWays = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    output dcache_pkg::miss_req_t miss_req_o,
    input  logic                  miss_gnt_i,
    input  dcache_pkg::refill_t   refill_i,
    input  logic                  critical_word_valid_i,
    input  dcache_pkg::word_t     critical_word_i
);

    // array side
    logic                                arr_req;
    logic                                arr_we;
    dcache_pkg::index_t                  arr_index;
    dcache_pkg::tag_t                    arr_tag;
    logic [NumWays-1:0]                  arr_way_we;
    logic                                arr_gnt;
    logic [NumWays-1:0]                  hit_way;
    dcache_pkg::line_t [NumWays-1:0]     rlines;
    dcache_pkg::line_t                   arr_wline;
    dcache_pkg::line_be_t                arr_wbe;
    // word mux side
    dcache_pkg::word_t                   hit_word;
    logic                                req_offset;
    dcache_pkg::be_t                     req_be;
    dcache_pkg::word_t                   req_wdata;

    cache_ctrl #(
        .NumWays (NumWays)
    ) i_cache_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .core_req_i            (core_req_i),
        .core_rsp_o            (core_rsp_o),
        .miss_req_o            (miss_req_o),
        .miss_gnt_i            (miss_gnt_i),
        .critical_word_valid_i (critical_word_valid_i),
        .critical_word_i       (critical_word_i),
        .arr_req_o             (arr_req),
        .arr_we_o              (arr_we),
        .arr_index_o           (arr_index),
        .arr_tag_o             (arr_tag),
        .arr_way_we_o          (arr_way_we),
        .arr_gnt_i             (arr_gnt),
        .hit_way_i             (hit_way),
        .hit_word_i            (hit_word),
        .req_offset_o          (req_offset),
        .req_be_o              (req_be),
        .req_wdata_o           (req_wdata)
    );

    line_word_mux #(
        .NumWays (NumWays)
    ) i_line_word_mux (
        .rlines_i   (rlines),
        .hit_way_i  (hit_way),
        .offset_i   (req_offset),
        .be_i       (req_be),
        .wdata_i    (req_wdata),
        .hit_word_o (hit_word),
        .wline_o    (arr_wline),
        .wbe_o      (arr_wbe)
    );

    tag_data_array #(
        .NumWays (NumWays)
    ) i_tag_data_array (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (arr_req),
        .we_i      (arr_we),
        .index_i   (arr_index),
        .tag_i     (arr_tag),
        .way_we_i  (arr_way_we),
        .wline_i   (arr_wline),
        .wbe_i     (arr_wbe),
        .refill_i  (refill_i),
        .gnt_o     (arr_gnt),
        .hit_way_o (hit_way),
        .rlines_o  (rlines)
    );

endmodule

//--- dcache/cache_ctrl.sv
`timescale 1ns/100ps
// data cache controller
// accepts core loads and stores, looks them up in the array, writes store
// hits in a second array access and hands misses to the miss unit
// loads are granted at acceptance, stores when they complete
module cache_ctrl #(
    parameter int unsigned NumWays = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // core port
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    // miss unit
    output dcache_pkg::miss_req_t miss_req_o,
    input  logic                  miss_gnt_i,
    input  logic                  critical_word_valid_i,
    input  dcache_pkg::word_t     critical_word_i,
    // array
    output logic                  arr_req_o,
    output logic                  arr_we_o,
    output dcache_pkg::index_t    arr_index_o,
    output dcache_pkg::tag_t      arr_tag_o,
    output logic [NumWays-1:0]    arr_way_we_o,
    input  logic                  arr_gnt_i,
    input  logic [NumWays-1:0]    hit_way_i,
    // word mux
    input  dcache_pkg::word_t     hit_word_i,
    output logic                  req_offset_o,
    output dcache_pkg::be_t       req_be_o,
    output dcache_pkg::word_t     req_wdata_o
);

    dcache_pkg::ctrl_state_e state_d, state_q;
    // request currently being served
    dcache_pkg::core_req_t   req_d, req_q;
    // way to write for a store hit
    logic [NumWays-1:0]      hit_way_d, hit_way_q;
    logic                    hit;
    logic                    next_load;

    assign hit       = |hit_way_i;
    // only loads may follow a load hit back to back
    assign next_load = core_req_i.req & ~core_req_i.we;

    // saved request drives word selection and store placement
    assign req_offset_o = req_q.addr[dcache_pkg::OffsetWidth-1];
    assign req_be_o     = req_q.be;
    assign req_wdata_o  = req_q.wdata;

    // --------------------
    // controller FSM
    // --------------------
    always_comb begin : ctrl_fsm
        state_d   = state_q;
        req_d     = req_q;
        hit_way_d = hit_way_q;

        core_rsp_o = '0;
        miss_req_o = '0;

        // default lookup address comes straight from the core
        arr_req_o    = 1'b0;
        arr_we_o     = 1'b0;
        arr_index_o  = core_req_i.addr[dcache_pkg::OffsetWidth +: dcache_pkg::IndexWidth];
        arr_tag_o    = core_req_i.addr[dcache_pkg::AddrWidth-1 -: dcache_pkg::TagWidth];
        arr_way_we_o = '0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (core_req_i.req) begin
                    arr_req_o = 1'b1;
                    // accept once the array takes the lookup
                    if (arr_gnt_i) begin
                        req_d          = core_req_i;
                        state_d        = dcache_pkg::WAIT_TAG;
                        core_rsp_o.gnt = ~core_req_i.we;
                    end
                end
            end

            // hit info for the saved request is valid now
            dcache_pkg::WAIT_TAG: begin
                core_rsp_o.rdata = hit_word_i;
                if (hit) begin
                    if (!req_q.we) begin
                        core_rsp_o.rvalid = 1'b1;
                        state_d           = dcache_pkg::IDLE;
                        // take the next load in the same cycle
                        if (next_load) begin
                            arr_req_o      = 1'b1;
                            req_d          = core_req_i;
                            core_rsp_o.gnt = 1'b1;
                            // lost the array, replay the saved index
                            state_d        = arr_gnt_i ? dcache_pkg::WAIT_TAG
                                                       : dcache_pkg::WAIT_GNT;
                        end
                    end else begin
                        // store needs a second access to write
                        hit_way_d = hit_way_i;
                        state_d   = dcache_pkg::STORE_REQ;
                    end
                end else begin
                    state_d = dcache_pkg::WAIT_REFILL_GNT;
                end
            end

            // load already granted, array grant still missing
            dcache_pkg::WAIT_GNT: begin
                arr_req_o   = 1'b1;
                arr_index_o = req_q.addr[dcache_pkg::OffsetWidth +: dcache_pkg::IndexWidth];
                arr_tag_o   = req_q.addr[dcache_pkg::AddrWidth-1 -: dcache_pkg::TagWidth];
                if (arr_gnt_i) begin
                    state_d = dcache_pkg::WAIT_TAG;
                end
            end

            // write the hit way, array sets the dirty bit
            dcache_pkg::STORE_REQ: begin
                arr_req_o    = 1'b1;
                arr_we_o     = 1'b1;
                arr_index_o  = req_q.addr[dcache_pkg::OffsetWidth +: dcache_pkg::IndexWidth];
                arr_tag_o    = req_q.addr[dcache_pkg::AddrWidth-1 -: dcache_pkg::TagWidth];
                arr_way_we_o = hit_way_q;
                if (arr_gnt_i) begin
                    core_rsp_o.gnt = 1'b1;
                    state_d        = dcache_pkg::IDLE;
                end
            end

            // fields come from registers so they stay stable until grant
            dcache_pkg::WAIT_REFILL_GNT: begin
                miss_req_o.valid = 1'b1;
                miss_req_o.we    = req_q.we;
                miss_req_o.addr  = req_q.addr;
                miss_req_o.be    = req_q.be;
                miss_req_o.wdata = req_q.wdata;
                if (miss_gnt_i) begin
                    if (req_q.we) begin
                        // store miss is done once the miss unit owns it
                        core_rsp_o.gnt = 1'b1;
                        state_d        = dcache_pkg::IDLE;
                    end else begin
                        state_d = dcache_pkg::WAIT_CRITICAL_WORD;
                    end
                end
            end

            // refill already written, the critical word ends the load
            dcache_pkg::WAIT_CRITICAL_WORD: begin
                core_rsp_o.rdata = critical_word_i;
                if (critical_word_valid_i) begin
                    core_rsp_o.rvalid = 1'b1;
                    state_d           = dcache_pkg::IDLE;
                end
            end

            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= dcache_pkg::IDLE;
            hit_way_q <= '0;
        end else begin
            state_q   <= state_d;
            hit_way_q <= hit_way_d;
        end
    end

    // saved request payload
    always_ff @(posedge clk_i) begin
        req_q <= req_d;
    end

endmodule

//--- dcache/line_word_mux.sv
`timescale 1ns/100ps
// hit way and word selection
// picks the hit line out of all ways, extracts the addressed word and
// places a store word with its byte enables inside a line
module line_word_mux #(
    parameter int unsigned NumWays = 4
) (
    input  dcache_pkg::line_t [NumWays-1:0] rlines_i,
    input  logic [NumWays-1:0]              hit_way_i,
    input  logic                            offset_i,
    input  dcache_pkg::be_t                 be_i,
    input  dcache_pkg::word_t               wdata_i,
    output dcache_pkg::word_t               hit_word_o,
    output dcache_pkg::line_t               wline_o,
    output dcache_pkg::line_be_t            wbe_o
);

    localparam int unsigned WordBytes = dcache_pkg::WordWidth / 8;

    dcache_pkg::line_t hit_line;

    // hit way is one hot, so an OR tree is enough
    always_comb begin : way_select
        hit_line = '0;
        for (int w = 0; w < NumWays; w++) begin
            if (hit_way_i[w]) begin
                hit_line = hit_line | rlines_i[w];
            end
        end
    end

    // lower or upper word of the line
    assign hit_word_o = hit_line[offset_i * dcache_pkg::WordWidth +: dcache_pkg::WordWidth];

    always_comb begin : store_place
        wline_o = '0;
        wbe_o   = '0;
        wline_o[offset_i * dcache_pkg::WordWidth +: dcache_pkg::WordWidth] = wdata_i;
        wbe_o[offset_i * WordBytes +: WordBytes] = be_i;
    end

endmodule

//--- dcache/tag_data_array.sv
`timescale 1ns/100ps
// tag and data array of the data cache
// per set and way storage of tag, valid, dirty and line data; lookups
// compare one cycle after grant, stores merge bytes and set dirty, and a
// refill takes priority, picks a victim way and blocks the grant
module tag_data_array #(
    parameter int unsigned NumWays = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_i,
    input  logic                            we_i,
    input  dcache_pkg::index_t              index_i,
    input  dcache_pkg::tag_t                tag_i,
    input  logic [NumWays-1:0]              way_we_i,
    input  dcache_pkg::line_t               wline_i,
    input  dcache_pkg::line_be_t            wbe_i,
    input  dcache_pkg::refill_t             refill_i,
    output logic                            gnt_o,
    output logic [NumWays-1:0]              hit_way_o,
    output dcache_pkg::line_t [NumWays-1:0] rlines_o
);

    localparam int unsigned WayBits   = (NumWays > 1) ? $clog2(NumWays) : 1;
    localparam int unsigned LineBytes = dcache_pkg::LineWidth / 8;

    dcache_pkg::tag_t  tag_q  [dcache_pkg::NumSets][NumWays];
    dcache_pkg::line_t data_q [dcache_pkg::NumSets][NumWays];
    logic [dcache_pkg::NumSets-1:0][NumWays-1:0] valid_q;
    logic [dcache_pkg::NumSets-1:0][NumWays-1:0] dirty_q;
    // round robin victim pointer per set
    logic [dcache_pkg::NumSets-1:0][WayBits-1:0] rr_q;

    dcache_pkg::index_t lookup_index_q;
    dcache_pkg::tag_t   lookup_tag_q;
    dcache_pkg::index_t refill_index;
    dcache_pkg::tag_t   refill_tag;
    logic [NumWays-1:0] victim_way;
    logic               all_valid;
    logic               lookup_en;
    logic               store_en;

    // refill owns the array in its cycle
    assign gnt_o     = req_i & ~refill_i.valid;
    assign lookup_en = gnt_o & ~we_i;
    assign store_en  = gnt_o & we_i;

    assign refill_index = refill_i.addr[dcache_pkg::OffsetWidth +: dcache_pkg::IndexWidth];
    assign refill_tag   = refill_i.addr[dcache_pkg::AddrWidth-1 -: dcache_pkg::TagWidth];
    assign all_valid    = &valid_q[refill_index];

    // first invalid way wins, otherwise the round robin pointer
    always_comb begin : victim_select
        victim_way = '0;
        if (all_valid) begin
            victim_way[rr_q[refill_index]] = 1'b1;
        end else begin
            for (int w = NumWays - 1; w >= 0; w--) begin
                if (!valid_q[refill_index][w]) begin
                    victim_way = NumWays'(1) << w;
                end
            end
        end
    end

    // --------------------
    // lookup compare
    // --------------------
    always_comb begin : hit_compare
        for (int w = 0; w < NumWays; w++) begin
            hit_way_o[w] = valid_q[lookup_index_q][w] &&
                           (tag_q[lookup_index_q][w] == lookup_tag_q);
            rlines_o[w]  = data_q[lookup_index_q][w];
        end
    end

    // --------------------
    // state bits
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
            rr_q    <= '0;
        end else if (refill_i.valid) begin
            // refilled line comes in valid and clean
            valid_q[refill_index] <= valid_q[refill_index] | victim_way;
            dirty_q[refill_index] <= dirty_q[refill_index] & ~victim_way;
            if (all_valid) begin
                rr_q[refill_index] <= (rr_q[refill_index] == WayBits'(NumWays - 1)) ?
                                      '0 : rr_q[refill_index] + 1'b1;
            end
        end else if (store_en) begin
            dirty_q[index_i] <= dirty_q[index_i] | way_we_i;
        end
    end

    // tags, line data and the lookup address
    always_ff @(posedge clk_i) begin
        if (lookup_en) begin
            lookup_index_q <= index_i;
            lookup_tag_q   <= tag_i;
        end
        for (int w = 0; w < NumWays; w++) begin
            if (refill_i.valid && victim_way[w]) begin
                tag_q[refill_index][w]  <= refill_tag;
                data_q[refill_index][w] <= refill_i.line;
            end else if (store_en && way_we_i[w]) begin
                // byte merge of the store word
                for (int b = 0; b < LineBytes; b++) begin
                    if (wbe_i[b]) begin
                        data_q[index_i][w][b*8 +: 8] <= wline_i[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- common/dcache_pkg.sv
// data cache shared definitions
// address split, vector types, port structs for the core and the miss
// unit, and the controller state encoding
package dcache_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned AddrWidth   = 32;
    localparam int unsigned WordWidth   = 64;
    localparam int unsigned LineWidth   = 128;
    localparam int unsigned NumSets     = 16;
    localparam int unsigned OffsetWidth = 4;
    localparam int unsigned IndexWidth  = 4;
    // tag is whatever is left above index and offset
    localparam int unsigned TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

    typedef logic [AddrWidth-1:0]     addr_t;
    typedef logic [WordWidth-1:0]     word_t;
    typedef logic [WordWidth/8-1:0]   be_t;
    typedef logic [LineWidth-1:0]     line_t;
    typedef logic [LineWidth/8-1:0]   line_be_t;
    typedef logic [IndexWidth-1:0]    index_t;
    typedef logic [TagWidth-1:0]      tag_t;

    // --------------------
    // port structs
    // --------------------
    // core request, held steady by the core until gnt
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        be_t   be;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } core_rsp_t;

    // request towards the miss unit, valid until miss_gnt
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        be_t   be;
        word_t wdata;
    } miss_req_t;

    // one cycle pulse carrying a whole line
    typedef struct packed {
        logic  valid;
        addr_t addr;
        line_t line;
    } refill_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_TAG,
        WAIT_GNT,
        STORE_REQ,
        WAIT_REFILL_GNT,
        WAIT_CRITICAL_WORD
    } ctrl_state_e;

endpackage
